// ==== Makefile ====
# Verilator build and run of the A-memory subsystem testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_amem with Verilator, run it, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary -j 0 --timescale 1ns/1ns --top-module tb_amem -f sources.f -o tb_amem
	-./obj_dir/tb_amem > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "test: FAIL"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "test: run ended without a result"; exit 1; fi
	@echo "test: PASS"

clean:
	rm -rf obj_dir $(LOG)

// ==== amem_alu_stage.sv ====
// ----------------------------------------------------------
// A-memory operand pipeline
// stage 0 issues the A read, stage 1 picks the operand
// (forwarded or from RAM) and runs the ALU into the
// writeback register that feeds result and RAM port A
// ----------------------------------------------------------

`timescale 1ns/1ns

`include "amem_cfg.svh"

module amem_alu_stage
(
   input  logic                      clk_a,
   input  logic                      reset,

   input  cadr_uinst_pkg::uinst_t    uinst,
   input  logic                      uinst_valid,
   output logic                      uinst_ready,
   input  logic                      hold,

   output logic [`AMEM_ADDR_W-1:0]   rd_addr,
   output logic                      rd_en,
   input  logic [`AMEM_DATA_W-1:0]   q_b,

   output cadr_uinst_pkg::result_t   wb,
   output logic                      wb_en,

   output cadr_uinst_pkg::result_t   result,
   output logic                      result_valid,
   output logic                      busy
);

   import cadr_uinst_pkg::*;

   logic                    in_run;        // low through reset
   logic                    accept;

   uinst_t                  s0_uinst;      // A read in flight
   logic                    s0_valid;

   uinst_t                  s1_uinst;      // operand available
   logic                    s1_valid;
   logic                    s1_fwd;        // take s1_fwd_data, not q_b
   logic [`AMEM_DATA_W-1:0] s1_fwd_data;

   logic                    fwd_hit_s1;
   logic                    fwd_hit_wb;
   logic [`AMEM_DATA_W-1:0] a_operand;
   logic [`AMEM_DATA_W-1:0] alu_y;

   result_t                 wb_r;
   logic                    wb_valid;
   logic                    wb_wr;

   assign uinst_ready = in_run & ~hold;
   assign accept      = uinst_valid & uinst_ready;

   // stage 0 reads A-memory at the next edge
   assign rd_addr = s0_uinst.a_addr;
   assign rd_en   = s0_valid;

   // a result that lands in RAM at or after the read edge would be missed by q_b
   assign fwd_hit_s1 = s1_valid && s1_uinst.wr_en && (s1_uinst.dest == s0_uinst.a_addr);
   assign fwd_hit_wb = wb_valid && wb_wr && (wb_r.dest == s0_uinst.a_addr);

   assign a_operand = s1_fwd ? s1_fwd_data : q_b;

   always_comb
   begin
      case (s1_uinst.op)
         pass_a:  alu_y = a_operand;
         pass_m:  alu_y = s1_uinst.m_operand;
         add:     alu_y = a_operand + s1_uinst.m_operand;
         sub:     alu_y = a_operand - s1_uinst.m_operand;
         and_op:  alu_y = a_operand & s1_uinst.m_operand;
         or_op:   alu_y = a_operand | s1_uinst.m_operand;
         xor_op:  alu_y = a_operand ^ s1_uinst.m_operand;
         default: alu_y = a_operand;    // unused code
      endcase
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         in_run   <= 1'b0;
         s0_valid <= 1'b0;
         s1_valid <= 1'b0;
         wb_valid <= 1'b0;
      end
      else
      begin
         in_run   <= 1'b1;
         s0_valid <= accept;
         s1_valid <= s0_valid;
         wb_valid <= s1_valid;
      end
   end

   always_ff @(posedge clk_a)
   begin
      if (accept)
         s0_uinst <= uinst;

      s1_uinst    <= s0_uinst;
      s1_fwd      <= fwd_hit_s1 | fwd_hit_wb;
      s1_fwd_data <= fwd_hit_s1 ? alu_y : wb_r.data;    // younger one first

      wb_r.dest <= s1_uinst.dest;
      wb_r.data <= alu_y;
      wb_wr     <= s1_uinst.wr_en;
   end

   assign wb    = wb_r;
   assign wb_en = wb_valid & wb_wr;

   assign result       = wb_r;
   assign result_valid = wb_valid;    // one strobe per item

   // anything still to read or write the RAM
   assign busy = s0_valid | s1_valid | wb_valid;

endmodule

// ==== amem_cfg.svh ====
// ----------------------------------------------------------
// A-memory sizes and ALU op code width
// ----------------------------------------------------------

`ifndef AMEM_CFG_SVH
`define AMEM_CFG_SVH

`define AMEM_ADDR_W 10      // word address bits
`define AMEM_DATA_W 32      // word width
`define AMEM_DEPTH  1024    // words in the scratchpad

`define ALU_OP_W    3       // op code bits of a microinstruction

`endif

// ==== amem_host_port.sv ====
// ----------------------------------------------------------
// Debug host slave for A-memory
// four-phase req/ack, holds the pipeline, waits for it
// to drain, then borrows RAM port A or port B
// ----------------------------------------------------------

`timescale 1ns/1ns

`include "amem_cfg.svh"

module amem_host_port
(
   input  logic                      clk_a,
   input  logic                      reset,

   input  host_pkg::host_req_t       host_req,
   input  logic                      req,
   output logic                      ack,
   output host_pkg::host_rsp_t       host_rsp,

   input  cadr_uinst_pkg::result_t   wb,
   input  logic                      wb_en,
   input  logic                      busy,
   input  logic [`AMEM_ADDR_W-1:0]   stage_rd_addr,
   input  logic                      stage_rd_en,
   output logic                      hold,

   input  logic [`AMEM_DATA_W-1:0]   q_b,
   output logic [`AMEM_ADDR_W-1:0]   address_a,
   output logic [`AMEM_DATA_W-1:0]   data_a,
   output logic                      wren_a,
   output logic [`AMEM_ADDR_W-1:0]   address_b,
   output logic                      rden_b
);

   typedef enum logic [2:0]
   {
      st_idle,
      st_drain,       // hold up, waiting for busy to fall
      st_access,      // host owns a RAM port for one edge
      st_capture,     // read data sits on q_b
      st_ack_high,
      st_release
   } state_e;

   state_e state;
   state_e state_nxt;
   logic   host_wr;
   logic   host_rd;

   always_ff @(posedge clk_a)
   begin
      if (reset)
         state <= st_idle;
      else
         state <= state_nxt;
   end

   always_comb
   begin
      state_nxt = state;
      case (state)
         st_idle:     if (req) state_nxt = st_drain;
         st_drain:    if (!busy) state_nxt = st_access;
         st_access:   state_nxt = host_req.write ? st_ack_high : st_capture;
         st_capture:  state_nxt = st_ack_high;
         st_ack_high: if (!req) state_nxt = st_release;
         st_release:  state_nxt = st_idle;
         default:     state_nxt = st_idle;
      endcase
   end

   assign hold = (state != st_idle);
   assign ack  = (state == st_ack_high);

   assign host_wr = (state == st_access) &&  host_req.write;
   assign host_rd = (state == st_access) && !host_req.write;

   // port A: pipeline writeback unless the host writes
   assign wren_a    = host_wr | wb_en;
   assign address_a = host_wr ? host_req.addr : wb.dest;
   assign data_a    = host_wr ? host_req.data : wb.data;

   // port B: stage 0 read unless the host reads
   assign rden_b    = host_rd | stage_rd_en;
   assign address_b = host_rd ? host_req.addr : stage_rd_addr;

   always_ff @(posedge clk_a)
   begin
      if (state == st_capture)
         host_rsp.rdata <= q_b;    // stays put until the next read
   end

endmodule

// ==== amem_subsystem_top.sv ====
// ----------------------------------------------------------
// A-memory subsystem: operand/ALU pipeline, debug host
// port and the 1Kx32 dual-port RAM
// ----------------------------------------------------------

`timescale 1ns/1ns

`include "amem_cfg.svh"

module amem_subsystem_top
(
   input  logic                      clk_a,
   input  logic                      reset,

   input  cadr_uinst_pkg::uinst_t    uinst,
   input  logic                      uinst_valid,
   output logic                      uinst_ready,

   output cadr_uinst_pkg::result_t   result,
   output logic                      result_valid,

   input  host_pkg::host_req_t       host_req,
   input  logic                      req,
   output logic                      ack,
   output host_pkg::host_rsp_t       host_rsp
);

   import cadr_uinst_pkg::*;

   logic [`AMEM_ADDR_W-1:0] rd_addr;
   logic                    rd_en;
   result_t                 wb;
   logic                    wb_en;
   logic                    hold;
   logic                    busy;

   logic [`AMEM_ADDR_W-1:0] address_a;
   logic [`AMEM_DATA_W-1:0] data_a;
   logic                    wren_a;
   logic [`AMEM_ADDR_W-1:0] address_b;
   logic                    rden_b;
   logic [`AMEM_DATA_W-1:0] q_b;

   amem_alu_stage u_alu_stage
   (
      .clk_a        (clk_a),
      .reset        (reset),
      .uinst        (uinst),
      .uinst_valid  (uinst_valid),
      .uinst_ready  (uinst_ready),
      .hold         (hold),
      .rd_addr      (rd_addr),
      .rd_en        (rd_en),
      .q_b          (q_b),
      .wb           (wb),
      .wb_en        (wb_en),
      .result       (result),
      .result_valid (result_valid),
      .busy         (busy)
   );

   amem_host_port u_host_port
   (
      .clk_a         (clk_a),
      .reset         (reset),
      .host_req      (host_req),
      .req           (req),
      .ack           (ack),
      .host_rsp      (host_rsp),
      .wb            (wb),
      .wb_en         (wb_en),
      .busy          (busy),
      .stage_rd_addr (rd_addr),
      .stage_rd_en   (rd_en),
      .hold          (hold),
      .q_b           (q_b),
      .address_a     (address_a),
      .data_a        (data_a),
      .wren_a        (wren_a),
      .address_b     (address_b),
      .rden_b        (rden_b)
   );

   // port A only writes, port B only reads
   part_1kx32dpram_a u_amem
   (
      .reset     (reset),
      .clk_a     (clk_a),
      .address_a (address_a),
      .data_a    (data_a),
      .wren_a    (wren_a),
      .rden_a    (1'b0),
      .clk_b     (clk_a),     // single clock domain
      .address_b (address_b),
      .data_b    ('0),
      .wren_b    (1'b0),
      .rden_b    (rden_b),
      .q_a       (),
      .q_b       (q_b)
   );

endmodule

// ==== cadr_uinst_pkg.sv ====
// ----------------------------------------------------------
// Datapath types: ALU op codes, the microinstruction word
// and the ALU result that goes to writeback
// ----------------------------------------------------------

`include "amem_cfg.svh"

package cadr_uinst_pkg;

   // operations of the A/M ALU
   typedef enum logic [`ALU_OP_W-1:0]
   {
      pass_a = 3'd0,    // A operand unchanged
      pass_m = 3'd1,    // M operand unchanged
      add    = 3'd2,
      sub    = 3'd3,    // A minus M
      and_op = 3'd4,
      or_op  = 3'd5,
      xor_op = 3'd6
   } alu_op_e;

   // one microinstruction, 56 bits
   typedef struct packed
   {
      alu_op_e                 op;
      logic [`AMEM_ADDR_W-1:0] a_addr;      // A-memory source word
      logic [`AMEM_DATA_W-1:0] m_operand;   // M side, already fetched
      logic [`AMEM_ADDR_W-1:0] dest;        // A-memory destination
      logic                    wr_en;       // write result back
   } uinst_t;

   // ALU result, 42 bits
   typedef struct packed
   {
      logic [`AMEM_ADDR_W-1:0] dest;
      logic [`AMEM_DATA_W-1:0] data;
   } result_t;

endpackage

// ==== host_pkg.sv ====
// ----------------------------------------------------------
// Debug host types: request and response of the
// four-phase A-memory access port
// ----------------------------------------------------------

`include "amem_cfg.svh"

package host_pkg;

   // held stable by the host while req is high
   typedef struct packed
   {
      logic                    write;   // 1 write, 0 read
      logic [`AMEM_ADDR_W-1:0] addr;
      logic [`AMEM_DATA_W-1:0] data;    // write data
   } host_req_t;

   // read data, meaningful once ack is high
   typedef struct packed
   {
      logic [`AMEM_DATA_W-1:0] rdata;
   } host_rsp_t;

endpackage

// ==== part_1kx32dpram_a.sv ====
// ----------------------------------------------------------
// Behavioral 1Kx32 dual-port A-memory RAM
// synchronous reads with old data on collision,
// port A wins when both ports write
// ----------------------------------------------------------

`timescale 1ns/1ns

`include "amem_cfg.svh"

module part_1kx32dpram_a
(
   input  logic                    reset,

   input  logic                    clk_a,
   input  logic [`AMEM_ADDR_W-1:0] address_a,
   input  logic [`AMEM_DATA_W-1:0] data_a,
   input  logic                    wren_a,
   input  logic                    rden_a,

   input  logic                    clk_b,
   input  logic [`AMEM_ADDR_W-1:0] address_b,
   input  logic [`AMEM_DATA_W-1:0] data_b,
   input  logic                    wren_b,
   input  logic                    rden_b,

   output logic [`AMEM_DATA_W-1:0] q_a,
   output logic [`AMEM_DATA_W-1:0] q_b
);

   logic [`AMEM_DATA_W-1:0] mem [0:`AMEM_DEPTH-1];

   // power-up contents are all zero
   initial
   begin
      for (int i = 0; i < `AMEM_DEPTH; i++)
      begin
         mem[i] = '0;
      end
   end

   // single write port in practice, A has priority
   always @(posedge clk_a)
   begin
      if (wren_a)
         mem[address_a] <= data_a;
      else if (wren_b)
         mem[address_b] <= data_b;
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
         q_a <= '0;
      else if (rden_a)
         q_a <= mem[address_a];    // old word on read-during-write
   end

   always_ff @(posedge clk_b)
   begin
      if (reset)
         q_b <= '0;
      else if (rden_b)
         q_b <= mem[address_b];
   end

endmodule

// ==== sources.f ====
+incdir+.
cadr_uinst_pkg.sv
host_pkg.sv
part_1kx32dpram_a.sv
amem_alu_stage.sv
amem_host_port.sv
amem_subsystem_top.sv
tb_amem.sv

// ==== tb_amem_vectors.svh ====
// ----------------------------------------------------------
// Directed steps for the A-memory testbench
// step kinds, the step struct and the step table
// ----------------------------------------------------------

`ifndef TB_AMEM_VECTORS_SVH
`define TB_AMEM_VECTORS_SVH

typedef enum logic [1:0]
{
   ent_hwrite,    // host write of data to addr
   ent_hread,     // host read, data is the expected word
   ent_uinst      // microinstruction, result from the mirror
} entry_kind_e;

typedef struct packed
{
   entry_kind_e             kind;
   logic [`AMEM_ADDR_W-1:0] addr;
   logic [`AMEM_DATA_W-1:0] data;
   uinst_t                  u;
} vec_entry_t;

localparam int num_vectors = 35;

// columns: kind, host address, host data or expected word, {op, a_addr, m, dest, wr_en}
localparam vec_entry_t vectors [0:num_vectors-1] = '{
   '{ent_hread,  10'h000, 32'h0000_0000, '0},    // RAM is clear after reset
   '{ent_hread,  10'h3ff, 32'h0000_0000, '0},
   '{ent_hwrite, 10'h010, 32'h1234_5678, '0},
   '{ent_hwrite, 10'h011, 32'h0000_00ff, '0},
   '{ent_hwrite, 10'h012, 32'hf0f0_0f0f, '0},
   '{ent_hwrite, 10'h3ff, 32'hdead_beef, '0},
   '{ent_hread,  10'h010, 32'h1234_5678, '0},
   '{ent_hread,  10'h011, 32'h0000_00ff, '0},
   '{ent_hread,  10'h012, 32'hf0f0_0f0f, '0},
   '{ent_hread,  10'h3ff, 32'hdead_beef, '0},
   // one of each op on the preloaded words
   '{ent_uinst,  10'h000, 32'h0, '{pass_a, 10'h010, 32'h1111_1111, 10'h020, 1'b1}},
   '{ent_uinst,  10'h000, 32'h0, '{pass_m, 10'h010, 32'hcafe_f00d, 10'h021, 1'b1}},
   '{ent_uinst,  10'h000, 32'h0, '{add,    10'h011, 32'h0000_0001, 10'h022, 1'b1}},
   '{ent_uinst,  10'h000, 32'h0, '{sub,    10'h011, 32'h0000_0100, 10'h023, 1'b1}},
   '{ent_uinst,  10'h000, 32'h0, '{and_op, 10'h012, 32'hff00_ff00, 10'h024, 1'b1}},
   '{ent_uinst,  10'h000, 32'h0, '{or_op,  10'h012, 32'h0f0f_0000, 10'h025, 1'b1}},
   '{ent_uinst,  10'h000, 32'h0, '{xor_op, 10'h3ff, 32'hffff_ffff, 10'h026, 1'b1}},
   '{ent_hread,  10'h026, 32'h2152_4110, '0},
   // dependent chain at distances one and two
   '{ent_uinst,  10'h000, 32'h0, '{add,    10'h030, 32'h0000_0005, 10'h030, 1'b1}},
   '{ent_uinst,  10'h000, 32'h0, '{add,    10'h030, 32'h0000_0003, 10'h031, 1'b1}},
   '{ent_uinst,  10'h000, 32'h0, '{add,    10'h030, 32'h0000_0010, 10'h032, 1'b1}},
   '{ent_uinst,  10'h000, 32'h0, '{add,    10'h031, 32'h0000_0001, 10'h031, 1'b1}},
   '{ent_uinst,  10'h000, 32'h0, '{sub,    10'h031, 32'h0000_0002, 10'h030, 1'b1}},
   '{ent_uinst,  10'h000, 32'h0, '{xor_op, 10'h030, 32'h0000_00ff, 10'h030, 1'b1}},
   '{ent_uinst,  10'h000, 32'h0, '{or_op,  10'h030, 32'h0000_0100, 10'h033, 1'b1}},
   '{ent_hread,  10'h030, 32'h0000_00f8, '0},
   '{ent_hread,  10'h033, 32'h0000_01f8, '0},
   // both older results match, the younger one must win
   '{ent_uinst,  10'h000, 32'h0, '{add,    10'h034, 32'h0000_0001, 10'h034, 1'b1}},
   '{ent_uinst,  10'h000, 32'h0, '{add,    10'h034, 32'h0000_0002, 10'h034, 1'b1}},
   '{ent_uinst,  10'h000, 32'h0, '{add,    10'h034, 32'h0000_0004, 10'h034, 1'b1}},
   '{ent_hread,  10'h034, 32'h0000_0007, '0},
   // results without writeback
   '{ent_uinst,  10'h000, 32'h0, '{pass_m, 10'h010, 32'h5555_aaaa, 10'h010, 1'b0}},
   '{ent_uinst,  10'h000, 32'h0, '{add,    10'h011, 32'h0000_0007, 10'h011, 1'b0}},
   '{ent_hread,  10'h010, 32'h1234_5678, '0},
   '{ent_hread,  10'h011, 32'h0000_00ff, '0}
};

`endif

// ==== tb_amem.sv ====
// ----------------------------------------------------------
// Testbench for the A-memory subsystem with clock and reset,
// directed table, random microinstruction stream with host
// accesses, mirror model of the RAM and the checks
// ----------------------------------------------------------

`timescale 1ns/1ns

`include "amem_cfg.svh"

module tb_amem;

   import cadr_uinst_pkg::*;
   import host_pkg::*;

   `include "tb_amem_vectors.svh"

   localparam int wait_limit = 100;    // cycles per wait
   localparam int num_random = 200;
   localparam logic [`AMEM_ADDR_W-1:0] rand_base = 10'h200;    // 16 words for the stream

   logic      clk_a;
   logic      reset;
   uinst_t    uinst;
   logic      uinst_valid;
   logic      uinst_ready;
   result_t   result;
   logic      result_valid;
   host_req_t host_req;
   logic      req;
   logic      ack;
   host_rsp_t host_rsp;

   logic [`AMEM_DATA_W-1:0] mirror [0:`AMEM_DEPTH-1];
   result_t want_q [$];    // results still to come
   int      due_q [$];     // falling edge each one is due at
   int      cyc;

   amem_subsystem_top dut
   (
      .clk_a        (clk_a),
      .reset        (reset),
      .uinst        (uinst),
      .uinst_valid  (uinst_valid),
      .uinst_ready  (uinst_ready),
      .result       (result),
      .result_valid (result_valid),
      .host_req     (host_req),
      .req          (req),
      .ack          (ack),
      .host_rsp     (host_rsp)
   );

   always #20 clk_a = ~clk_a;

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [`AMEM_DATA_W-1:0] got,
                              input logic [`AMEM_DATA_W-1:0] expected);
      if (got !== expected)
         fail_run($sformatf("[FAIL] %0t ns: %s = %h, expected %h", $time, name, got, expected));
   endtask

   function automatic logic [`AMEM_DATA_W-1:0] alu_ref(input alu_op_e op,
      input logic [`AMEM_DATA_W-1:0] a, input logic [`AMEM_DATA_W-1:0] m);
      case (op)
         pass_a:  return a;
         pass_m:  return m;
         add:     return a + m;
         sub:     return a - m;
         and_op:  return a & m;
         or_op:   return a | m;
         xor_op:  return a ^ m;
         default: return a;
      endcase
   endfunction

   // every step of the run goes through here so no result is missed
   task automatic next_negedge();
      @(negedge clk_a);
      cyc++;
      if (result_valid)
      begin
         if (want_q.size() == 0)
            fail_run("result_valid went high with no microinstruction outstanding");
         else
         begin
            check_value("result_valid cycle", cyc, due_q[0]);
            check_value("result.dest", 32'(result.dest), 32'(want_q[0].dest));
            check_value("result.data", result.data, want_q[0].data);
            void'(want_q.pop_front());
            void'(due_q.pop_front());
         end
      end
      else if (due_q.size() != 0 && due_q[0] <= cyc)
         fail_run("result_valid did not rise two cycles after acceptance");
   endtask

   task automatic issue_uinst(input uinst_t u);
      int      waited;
      result_t want;
      waited = 0;
      uinst = u;
      uinst_valid = 1'b1;
      while (!uinst_ready)
      begin
         if (waited == wait_limit)
            fail_run("timeout waiting for uinst_ready");
         waited++;
         next_negedge();
      end
      want.dest = u.dest;
      want.data = alu_ref(u.op, mirror[u.a_addr], u.m_operand);
      if (u.wr_en)
         mirror[u.dest] = want.data;
      want_q.push_back(want);
      due_q.push_back(cyc + 3);    // accept edge plus two more
      next_negedge();
      uinst_valid = 1'b0;
   endtask

   task automatic host_access(input logic write, input logic [`AMEM_ADDR_W-1:0] addr,
                              input logic [`AMEM_DATA_W-1:0] data,
                              output logic [`AMEM_DATA_W-1:0] rdata);
      int waited;
      check_value("ack", 32'(ack), 32'd0);
      host_req.write = write;
      host_req.addr  = addr;
      host_req.data  = data;
      req = 1'b1;
      waited = 0;
      do
      begin
         if (waited == wait_limit)
            fail_run("timeout waiting for ack to rise");
         waited++;
         next_negedge();
         check_value("uinst_ready", 32'(uinst_ready), 32'd0);    // pipeline held
      end
      while (!ack);
      rdata = host_rsp.rdata;
      next_negedge();
      check_value("ack", 32'(ack), 32'd1);    // stays up while req is high
      req = 1'b0;
      waited = 0;
      do
      begin
         if (waited == wait_limit)
            fail_run("timeout waiting for ack to fall");
         waited++;
         next_negedge();
      end
      while (ack);
      // hold drops once the port is back in idle
      waited = 0;
      while (!uinst_ready)
      begin
         if (waited == wait_limit)
            fail_run("timeout waiting for the host port to release the pipeline");
         waited++;
         next_negedge();
      end
      if (write)
         mirror[addr] = data;
   endtask

   initial
   begin
      uinst_t                  u;
      logic [`AMEM_DATA_W-1:0] rd;
      int                      waited;
      void'($urandom(75336));
      clk_a       = 1'b0;
      reset       = 1'b1;
      uinst       = '0;
      uinst_valid = 1'b0;
      host_req    = '0;
      req         = 1'b0;
      cyc         = 0;
      for (int i = 0; i < `AMEM_DEPTH; i++)
         mirror[i] = '0;

      repeat (3)
      begin
         @(negedge clk_a);
         check_value("uinst_ready", 32'(uinst_ready), 32'd0);
         check_value("ack", 32'(ack), 32'd0);
         check_value("result_valid", 32'(result_valid), 32'd0);
      end
      reset = 1'b0;
      repeat (4) next_negedge();    // idle with no result allowed

      for (int i = 0; i < num_vectors; i++)
      begin
         case (vectors[i].kind)
            ent_hwrite: host_access(1'b1, vectors[i].addr, vectors[i].data, rd);
            ent_hread:
            begin
               host_access(1'b0, vectors[i].addr, '0, rd);
               check_value("host_rsp.rdata", rd, vectors[i].data);
            end
            default:    issue_uinst(vectors[i].u);
         endcase
      end

      for (int n = 0; n < num_random; n++)
      begin
         u.op        = alu_op_e'(3'($urandom % 7));
         u.a_addr    = rand_base | 10'($urandom % 16);
         u.m_operand = $urandom;
         u.dest      = rand_base | 10'($urandom % 16);
         u.wr_en     = ($urandom % 4) != 0;
         issue_uinst(u);
         if ($urandom % 6 == 0)
            next_negedge();    // gap that changes the dependency distance
         if (n == 70)
            host_access(1'b1, rand_base | 10'd5, $urandom, rd);
         if (n == 140)
         begin
            host_access(1'b0, rand_base | 10'd9, '0, rd);
            check_value("host_rsp.rdata", rd, mirror[rand_base | 10'd9]);
         end
      end

      waited = 0;
      while (want_q.size() != 0)
      begin
         if (waited == wait_limit)
            fail_run("timeout waiting for the last results");
         waited++;
         next_negedge();
      end

      for (int a = 0; a < 16; a++)
      begin
         host_access(1'b0, rand_base | 10'(a), '0, rd);
         check_value("host_rsp.rdata", rd, mirror[rand_base | 10'(a)]);
      end

      $display("Simulation completed successfully");
      $finish;
   end

endmodule
